// File: mmuPkg.sv
// mmu shared package: TLB geometry, segment bounds and the address, entry and stage types
package mmuPkg;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_W = 4;
    localparam int ASID_W      = 8;

    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000; // unmapped, cached
    localparam logic [31:0] KSEG1_BASE = 32'hA000_0000; // unmapped, uncached
    localparam logic [31:0] KSEG2_BASE = 32'hC000_0000; // mapped again from here up

    localparam logic [2:0] CACHE_CACHED = 3'd3;

    // one virtual address word, seen raw or split into page fields
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [18:0] vpn2;
            logic        oddPage;  // picks half1 of the entry
            logic [11:0] offset;
        } page;
    } vaddr_u;

    typedef struct packed {
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } pageHalf_t;

    typedef struct packed {
        logic [18:0]       vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        pageHalf_t         half0;
        pageHalf_t         half1;
    } tlbEntry_t;

    typedef struct packed {
        logic   valid;
        vaddr_u vaddr;
        logic   rd;
        logic   wr;
    } mmuReq_t;

    // stage one register plus the TLB answer for it
    typedef struct packed {
        logic                   valid;
        vaddr_u                 vaddr;
        logic                   rd;
        logic                   wr;
        logic                   probe;
        logic                   mapped;
        logic                   uncached;
        logic                   found;
        logic [TLB_INDEX_W-1:0] index;
        pageHalf_t              half;
    } lookupRes_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        cached;
        logic        refill;
        logic        invalid;
        logic        modified;
    } mmuResp_t;

endpackage

// File: tlbArray.sv
// 16-entry fully associative TLB with two search ports, a write port and a registered read port
module tlbArray
    import mmuPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ASID_W-1:0]      asid,
    input  logic [18:0]            search0Vpn2,
    input  logic [18:0]            search1Vpn2,
    input  logic                   search0Odd,
    input  logic                   search1Odd,
    output logic                   search0Found,
    output logic                   search1Found,
    output logic [TLB_INDEX_W-1:0] search0Index,
    output logic [TLB_INDEX_W-1:0] search1Index,
    output pageHalf_t              search0Half,
    output pageHalf_t              search1Half,
    input  logic                   write,
    input  logic [TLB_INDEX_W-1:0] writeIndex,
    input  tlbEntry_t              writeEntry,
    input  logic                   read,
    input  logic [TLB_INDEX_W-1:0] readIndex,
    output tlbEntry_t              readEntry
);

    tlbEntry_t entries [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] hits0;
    logic [TLB_ENTRIES-1:0] hits1;

    function automatic logic entryHit(tlbEntry_t e, logic [18:0] vpn2, logic [ASID_W-1:0] curAsid);
        return (e.vpn2 == vpn2) && (e.g || e.asid == curAsid);
    endfunction

    // returns {found, index}, lowest index wins
    function automatic logic [TLB_INDEX_W:0] firstHit(logic [TLB_ENTRIES-1:0] hits);
        logic [TLB_INDEX_W:0] r;
        r = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                r = {1'b1, TLB_INDEX_W'(i)};
            end
        end
        return r;
    endfunction

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hits0[i] = entryHit(entries[i], search0Vpn2, asid);
            hits1[i] = entryHit(entries[i], search1Vpn2, asid);
        end
    end

    always_comb begin
        {search0Found, search0Index} = firstHit(hits0);
        {search1Found, search1Index} = firstHit(hits1);
        search0Half = search0Odd ? entries[search0Index].half1 : entries[search0Index].half0;
        search1Half = search1Odd ? entries[search1Index].half1 : entries[search1Index].half0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (write) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    // read data held until the next read
    always_ff @(posedge clk) begin
        if (read) begin
            readEntry <= entries[readIndex];
        end
    end

endmodule

// File: mmuLookupStage.sv
// mmu lookup stage: registers a request or probe, decodes its segment and drives a TLB search
module mmuLookupStage
    import mmuPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  mmuReq_t                req,
    input  logic                   probe,
    input  logic [18:0]            probeVpn2,
    output logic [18:0]            searchVpn2,
    output logic                   searchOdd,
    input  logic                   found,
    input  logic [TLB_INDEX_W-1:0] index,
    input  pageHalf_t              half,
    output lookupRes_t             res
);

    logic   kseg0;
    logic   kseg1;
    logic   validQ;
    logic   probeQ;
    logic   rdQ;
    logic   wrQ;
    logic   mappedQ;
    logic   uncachedQ;
    vaddr_u vaddrQ;

    assign kseg0 = (req.vaddr.word >= KSEG0_BASE) && (req.vaddr.word < KSEG1_BASE);
    assign kseg1 = (req.vaddr.word >= KSEG1_BASE) && (req.vaddr.word < KSEG2_BASE);

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
            probeQ <= 1'b0;
        end else begin
            validQ <= req.valid && !probe; // probe takes the slot
            probeQ <= probe;
        end
    end

    always_ff @(posedge clk) begin
        if (probe) begin
            vaddrQ.page.vpn2    <= probeVpn2;
            vaddrQ.page.oddPage <= 1'b0;
            vaddrQ.page.offset  <= '0;
            mappedQ             <= 1'b1;
            uncachedQ           <= 1'b0;
            rdQ                 <= 1'b0;
            wrQ                 <= 1'b0;
        end else begin
            vaddrQ    <= req.vaddr;
            mappedQ   <= !(kseg0 || kseg1);
            uncachedQ <= kseg1;
            rdQ       <= req.rd;
            wrQ       <= req.wr;
        end
    end

    assign searchVpn2 = vaddrQ.page.vpn2;
    assign searchOdd  = vaddrQ.page.oddPage;

    always_comb begin
        res.valid    = validQ;
        res.vaddr    = vaddrQ;
        res.rd       = rdQ;
        res.wr       = wrQ;
        res.probe    = probeQ;
        res.mapped   = mappedQ;
        res.uncached = uncachedQ;
        res.found    = found;
        res.index    = index;
        res.half     = half;
    end

endmodule

// File: mmuResolveStage.sv
// mmu resolve stage: forms the physical address, cacheability and TLB exceptions, then registers them
module mmuResolveStage
    import mmuPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  lookupRes_t             res,
    output mmuResp_t               resp,
    output logic                   probeValid,
    output logic                   probeFound,
    output logic [TLB_INDEX_W-1:0] probeIndex
);

    mmuResp_t next;

    always_comb begin
        next       = '0;
        next.valid = res.valid;
        if (!res.mapped) begin
            // fixed windows, no TLB involved
            next.paddr  = res.vaddr.word - (res.uncached ? KSEG1_BASE : KSEG0_BASE);
            next.cached = !res.uncached;
        end else begin
            next.paddr  = {res.half.pfn, res.vaddr.page.offset};
            next.cached = (res.half.c == CACHE_CACHED);
            if (res.valid && (res.rd || res.wr)) begin
                if (!res.found) begin
                    next.refill = 1'b1;
                end else if (!res.half.v) begin
                    next.invalid = 1'b1;
                end else if (res.wr && !res.half.d) begin
                    next.modified = 1'b1; // store to clean page
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid    <= 1'b0;
            resp.refill   <= 1'b0;
            resp.invalid  <= 1'b0;
            resp.modified <= 1'b0;
        end else begin
            resp.valid    <= next.valid;
            resp.refill   <= next.refill;
            resp.invalid  <= next.invalid;
            resp.modified <= next.modified;
        end
    end

    always_ff @(posedge clk) begin
        resp.paddr  <= next.paddr;
        resp.cached <= next.cached;
    end

    // probe answer uses the data response slot
    always_ff @(posedge clk) begin
        if (rst) begin
            probeValid <= 1'b0;
            probeFound <= 1'b0;
        end else begin
            probeValid <= res.probe;
            probeFound <= res.probe && res.found;
        end
    end

    always_ff @(posedge clk) begin
        probeIndex <= res.index;
    end

endmodule

// File: tlbMmu.sv
// address translation unit top: instruction path, data/probe path and shared TLB
module tlbMmu
    import mmuPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [ASID_W-1:0]      asid,
    input  mmuReq_t                iReq,
    input  mmuReq_t                dReq,
    input  logic                   probe,
    input  logic [18:0]            probeVpn2,
    input  logic                   tlbWrite,
    input  logic                   tlbRead,
    input  logic [TLB_INDEX_W-1:0] tlbIndex,
    input  tlbEntry_t              writeEntry,
    output mmuResp_t               iResp,
    output mmuResp_t               dResp,
    output logic                   probeValid,
    output logic                   probeFound,
    output logic [TLB_INDEX_W-1:0] probeIndex,
    output tlbEntry_t              readEntry
);

    mmuReq_t                iFetch;
    logic [18:0]            iSearchVpn2;
    logic [18:0]            dSearchVpn2;
    logic                   iSearchOdd;
    logic                   dSearchOdd;
    logic                   iFound;
    logic                   dFound;
    logic [TLB_INDEX_W-1:0] iIndex;
    logic [TLB_INDEX_W-1:0] dIndex;
    pageHalf_t              iHalf;
    pageHalf_t              dHalf;
    lookupRes_t             iRes;
    lookupRes_t             dRes;

    // a fetch always counts as a read
    assign iFetch = '{valid: iReq.valid, vaddr: iReq.vaddr, rd: 1'b1, wr: 1'b0};

    tlbArray uTlb (
        .clk          (clk),
        .rst          (rst),
        .asid         (asid),
        .search0Vpn2  (iSearchVpn2),
        .search1Vpn2  (dSearchVpn2),
        .search0Odd   (iSearchOdd),
        .search1Odd   (dSearchOdd),
        .search0Found (iFound),
        .search1Found (dFound),
        .search0Index (iIndex),
        .search1Index (dIndex),
        .search0Half  (iHalf),
        .search1Half  (dHalf),
        .write        (tlbWrite),
        .writeIndex   (tlbIndex),
        .writeEntry   (writeEntry),
        .read         (tlbRead),
        .readIndex    (tlbIndex),
        .readEntry    (readEntry)
    );

    mmuLookupStage uILookup (
        .clk        (clk),
        .rst        (rst),
        .req        (iFetch),
        .probe      (1'b0),  // no probes on fetch side
        .probeVpn2  ('0),
        .searchVpn2 (iSearchVpn2),
        .searchOdd  (iSearchOdd),
        .found      (iFound),
        .index      (iIndex),
        .half       (iHalf),
        .res        (iRes)
    );

    mmuLookupStage uDLookup (
        .clk        (clk),
        .rst        (rst),
        .req        (dReq),
        .probe      (probe),
        .probeVpn2  (probeVpn2),
        .searchVpn2 (dSearchVpn2),
        .searchOdd  (dSearchOdd),
        .found      (dFound),
        .index      (dIndex),
        .half       (dHalf),
        .res        (dRes)
    );

    mmuResolveStage uIResolve (
        .clk        (clk),
        .rst        (rst),
        .res        (iRes),
        .resp       (iResp),
        .probeValid (),
        .probeFound (),
        .probeIndex ()
    );

    mmuResolveStage uDResolve (
        .clk        (clk),
        .rst        (rst),
        .res        (dRes),
        .resp       (dResp),
        .probeValid (probeValid),
        .probeFound (probeFound),
        .probeIndex (probeIndex)
    );

endmodule

// File: tbClock.sv
// testbench clock source, free running with a 10 unit period
module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

// File: tlbMmu_chk.sv
// timing checks on the mmu top: quiet reset, fetch latency and exception flags
module tlbMmu_chk
    import mmuPkg::*;
(
    input logic     clk,
    input logic     rst,
    input mmuReq_t  iReq,
    input mmuResp_t iResp,
    input mmuResp_t dResp,
    input logic     probeValid
);

    logic rstQ; // reset seen one edge earlier

    always_ff @(posedge clk) begin
        rstQ <= rst;
    end

    quietInReset: assert property (@(posedge clk)
        rst && rstQ |-> !iResp.valid && !dResp.valid && !probeValid)
        else $error("response or probe valid while in reset");

    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        iResp.valid == $past(iReq.valid, 2))
        else $error("fetch response not two cycles after its request");

    // refill, invalid and modified never together
    oneException: assert property (@(posedge clk) disable iff (rst)
        $onehot0({iResp.refill, iResp.invalid, iResp.modified})
        && $onehot0({dResp.refill, dResp.invalid, dResp.modified}))
        else $error("more than one exception flag set");

endmodule

// File: tlbMmuTb.sv
// testbench for the mmu top: directed tests against a reference TLB model
module tlbMmuTb
    import mmuPkg::*;
();

    // cycles per test, used to size the watchdog
    localparam int RESET_CYC    = 4;
    localparam int UNMAPPED_CYC = 16;
    localparam int MAPPED_CYC   = 18;
    localparam int EXCEPT_CYC   = 13;
    localparam int PROBE_CYC    = 4;
    localparam int READ_CYC     = 3;
    localparam int PIPE_CYC     = 7;
    localparam int RUN_CYC      = RESET_CYC + UNMAPPED_CYC + MAPPED_CYC + EXCEPT_CYC
                                + PROBE_CYC + READ_CYC + PIPE_CYC;

    logic                   clk;
    logic                   rst;
    logic [ASID_W-1:0]      asid;
    mmuReq_t                iReq;
    mmuReq_t                dReq;
    logic                   probe;
    logic [18:0]            probeVpn2;
    logic                   tlbWrite;
    logic                   tlbRead;
    logic [TLB_INDEX_W-1:0] tlbIndex;
    tlbEntry_t              writeEntry;
    mmuResp_t               iResp;
    mmuResp_t               dResp;
    logic                   probeValid;
    logic                   probeFound;
    logic [TLB_INDEX_W-1:0] probeIndex;
    tlbEntry_t              readEntry;

    tlbEntry_t model [TLB_ENTRIES]; // mirror of every TLB write
    int        seed      = 86;
    int        errCount  = 0;
    int        testCount = 0;
    int        failTests = 0;

    tbClock uClk (.clk(clk));

    tlbMmu uut (.*);

    bind tlbMmu tlbMmu_chk uChk (
        .clk        (clk),
        .rst        (rst),
        .iReq       (iReq),
        .iResp      (iResp),
        .dResp      (dResp),
        .probeValid (probeValid)
    );

    // {found, index}, first match from index 0 up
    function automatic logic [4:0] modelSearch(logic [18:0] vpn2);
        logic [4:0] r;
        r = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!r[4] && model[4'(i)].vpn2 == vpn2
                    && (model[4'(i)].g || model[4'(i)].asid == asid)) begin
                r = {1'b1, 4'(i)};
            end
        end
        return r;
    endfunction

    function automatic mmuResp_t expectResp(logic [31:0] va, logic rd, logic wr);
        mmuResp_t   e;
        logic [4:0] hit;
        pageHalf_t  h;
        e = '0;
        e.valid = 1'b1;
        if (va >= 32'h8000_0000 && va < 32'hA000_0000) begin
            e.paddr  = va - 32'h8000_0000;
            e.cached = 1'b1;
        end else if (va >= 32'hA000_0000 && va < 32'hC000_0000) begin
            e.paddr = va - 32'hA000_0000; // kseg1, uncached
        end else begin
            hit = modelSearch(va[31:13]);
            h = va[12] ? model[hit[3:0]].half1 : model[hit[3:0]].half0;
            e.paddr  = {h.pfn, va[11:0]};
            e.cached = (h.c == 3'd3);
            if (!hit[4]) begin
                e.refill = rd || wr;
            end else if (!h.v) begin
                e.invalid = rd || wr;
            end else if (wr && !h.d) begin
                e.modified = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic compareResp(input string name, input mmuResp_t exp, input mmuResp_t act);
        mmuResp_t want;
        want = exp;
        if (exp.refill) begin
            want.paddr  = act.paddr;  // no page behind a miss
            want.cached = act.cached;
        end
        if (act !== want) begin
            $display("Fail %s: expected %h, actual %h", name, want, act);
            errCount++;
        end
    endtask

    task automatic driveReq(input logic [31:0] iVa, input logic [31:0] dVa,
                            input logic rd, input logic wr);
        iReq.valid      = 1'b1;
        iReq.vaddr.word = iVa;
        dReq.valid      = 1'b1;
        dReq.vaddr.word = dVa;
        dReq.rd         = rd;
        dReq.wr         = wr;
    endtask

    // one request on each path, answer checked two edges later
    task automatic translate(input string name, input logic [31:0] iVa,
                             input logic [31:0] dVa, input logic rd, input logic wr);
        mmuResp_t iExp;
        mmuResp_t dExp;
        iExp = expectResp(iVa, 1'b1, 1'b0);
        dExp = expectResp(dVa, rd, wr);
        driveReq(iVa, dVa, rd, wr);
        @(posedge clk);
        @(negedge clk);
        iReq.valid = 1'b0;
        dReq.valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
        compareResp({name, " ifetch"}, iExp, iResp);
        compareResp({name, " data"}, dExp, dResp);
    endtask

    // random pfns, half0 cacheable and half1 not
    task automatic loadEntry(input logic [3:0] idx, input logic [18:0] vpn2,
                             input logic [7:0] id, input logic g, input logic vBit,
                             input logic dBit);
        tlbEntry_t   e;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        e.vpn2  = vpn2;
        e.asid  = id;
        e.g     = g;
        e.half0 = '{pfn: r0[19:0], c: 3'd3, d: dBit, v: vBit};
        e.half1 = '{pfn: r1[19:0], c: 3'd2, d: dBit, v: vBit};
        tlbWrite   = 1'b1;
        tlbIndex   = idx;
        writeEntry = e;
        @(negedge clk);
        tlbWrite   = 1'b0;
        model[idx] = e;
    endtask

    task automatic endTest(input string name, input int errsBefore);
        testCount++;
        if (errCount == errsBefore) begin
            $display("%s: ok", name);
        end else begin
            failTests++;
            $display("%s: %0d mismatches", name, errCount - errsBefore);
        end
    endtask

    task automatic testUnmapped();
        int          errsBefore;
        logic [31:0] r;
        errsBefore = errCount;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            translate("kseg0/kseg1", {3'b100, r[28:0]}, {3'b101, r[31:3]}, 1'b1, 1'b0);
            translate("kseg1/kseg0", {3'b101, r[28:0]}, {3'b100, r[31:3]}, 1'b0, 1'b1);
        end
        endTest("unmapped", errsBefore);
    endtask

    task automatic testMappedHit();
        int          errsBefore;
        logic [31:0] r;
        logic [18:0] vGlob;
        logic [18:0] vOwn;
        errsBefore = errCount;
        r = $random(seed);
        vGlob = {1'b0, r[17:0]};   // kuseg page
        vOwn  = {2'b11, r[31:15]}; // kseg2 page
        asid  = 8'd5;
        loadEntry(4'd3, vGlob, 8'd9, 1'b1, 1'b1, 1'b1);
        loadEntry(4'd7, vOwn, 8'd5, 1'b0, 1'b1, 1'b1);
        for (int i = 0; i < 2; i++) begin
            r = $random(seed);
            translate("global hit", {vGlob, 1'b0, r[11:0]}, {vGlob, 1'b1, r[23:12]}, 1'b1, 1'b0);
            translate("global hit", {vGlob, 1'b1, r[11:0]}, {vGlob, 1'b0, r[23:12]}, 1'b0, 1'b1);
            translate("asid hit", {vOwn, 1'b0, r[11:0]}, {vOwn, 1'b1, r[23:12]}, 1'b1, 1'b0);
            translate("asid hit", {vOwn, 1'b1, r[11:0]}, {vOwn, 1'b0, r[23:12]}, 1'b0, 1'b1);
        end
        endTest("mapped hit", errsBefore);
    endtask

    task automatic testExceptions();
        int errsBefore;
        errsBefore = errCount;
        loadEntry(4'd10, 19'h0_1A2B, 8'd5, 1'b1, 1'b0, 1'b1); // v clear
        loadEntry(4'd11, 19'h0_2B3C, 8'd5, 1'b1, 1'b1, 1'b0); // d clear
        loadEntry(4'd12, 19'h0_3C4D, 8'd7, 1'b0, 1'b1, 1'b1);
        translate("miss", {19'h2_5AA5, 13'h0123}, {19'h2_5AA5, 13'h1456}, 1'b1, 1'b0);
        translate("invalid", {19'h0_1A2B, 13'h0040}, {19'h0_1A2B, 13'h1080}, 1'b1, 1'b0);
        translate("store clean", {19'h0_2B3C, 13'h0010}, {19'h0_2B3C, 13'h1020}, 1'b0, 1'b1);
        translate("load clean", {19'h0_2B3C, 13'h1010}, {19'h0_2B3C, 13'h0020}, 1'b1, 1'b0);
        translate("asid miss", {19'h0_3C4D, 13'h0ABC}, {19'h0_3C4D, 13'h1DEF}, 1'b1, 1'b0);
        endTest("exceptions", errsBefore);
    endtask

    task automatic probeCheck(input string name, input logic [18:0] vpn2);
        logic [4:0] exp;
        exp = modelSearch(vpn2);
        probe     = 1'b1;
        probeVpn2 = vpn2;
        @(posedge clk);
        @(negedge clk);
        probe = 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (probeValid !== 1'b1 || dResp.valid !== 1'b0) begin
            $display("Fail %s: probe result missing or a data response took its slot", name);
            errCount++;
        end
        if (probeFound !== exp[4] || (exp[4] && probeIndex !== exp[3:0])) begin
            $display("Fail %s: expected %h, actual %h", name, exp, {probeFound, probeIndex});
            errCount++;
        end
    endtask

    task automatic testProbe();
        int errsBefore;
        errsBefore = errCount;
        probeCheck("probe hit", model[7].vpn2);
        probeCheck("probe miss", 19'h2_5AA5);
        endTest("probe", errsBefore);
    endtask

    task automatic testReadBack();
        int         errsBefore;
        logic [3:0] idx;
        errsBefore = errCount;
        for (int k = 0; k < 3; k++) begin
            idx = 4'(3 + 4 * k);
            tlbRead  = 1'b1;
            tlbIndex = idx;
            @(negedge clk);
            tlbRead = 1'b0;
            if (readEntry !== model[idx]) begin
                $display("Fail read back: expected %h, actual %h", model[idx], readEntry);
                errCount++;
            end
        end
        endTest("read back", errsBefore);
    endtask

    // four requests back to back, answers must come out in order
    task automatic testPipeline();
        int          errsBefore;
        logic [31:0] r;
        logic [31:0] iVa;
        logic [31:0] dVa;
        mmuResp_t    iExp [$];
        mmuResp_t    dExp [$];
        errsBefore = errCount;
        for (int c = 0; c < 7; c++) begin
            if (c >= 2 && c < 6) begin
                compareResp("pipeline ifetch", iExp.pop_front(), iResp);
                compareResp("pipeline data", dExp.pop_front(), dResp);
            end
            if (c == 6 && (iResp.valid || dResp.valid)) begin
                $display("Fail pipeline: a response stayed valid after the last request");
                errCount++;
            end
            if (c < 4) begin
                r = $random(seed);
                iVa = c[0] ? {3'b100, r[28:0]} : {model[3].vpn2, r[12:0]};
                dVa = c[0] ? {model[7].vpn2, r[12:0]} : {3'b101, r[28:0]};
                iExp.push_back(expectResp(iVa, 1'b1, 1'b0));
                dExp.push_back(expectResp(dVa, 1'b1, 1'b0));
                driveReq(iVa, dVa, 1'b1, 1'b0);
            end else begin
                iReq.valid = 1'b0;
                dReq.valid = 1'b0;
            end
            @(negedge clk);
        end
        endTest("pipeline", errsBefore);
    endtask

    initial begin
        rst        = 1'b1;
        asid       = '0;
        iReq       = '0;
        dReq       = '0;
        probe      = 1'b0;
        probeVpn2  = '0;
        tlbWrite   = 1'b0;
        tlbRead    = 1'b0;
        tlbIndex   = '0;
        writeEntry = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model[4'(i)] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testUnmapped();
        testMappedHit();
        testExceptions();
        testProbe();
        testReadBack();
        testPipeline();
        $display("tests run %0d, clean %0d, failing %0d", testCount,
                 testCount - failTests, failTests);
        if (failTests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, twice the expected run length
    initial begin
        #(RUN_CYC * 2 * 10);
        $display("watchdog: run timed out after %0d cycles", RUN_CYC * 2);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: vlog.f
mmuPkg.sv
tlbArray.sv
mmuLookupStage.sv
mmuResolveStage.sv
tlbMmu.sv
tbClock.sv
tlbMmu_chk.sv
tlbMmuTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tlbMmuTb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
